/* hdl/hl_ctrl_pkg.sv */
package hl_ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // widths that carry a meaning
  ////////////////////////////////////////////////////////////

  // register address from byte 0 of a command frame
  typedef logic [5:0]  cmd_addr_t;
  typedef logic [31:0] cmd_data_t;

  // marker, echoed address, readback data
  typedef logic [39:0] resp_t;

  typedef logic [47:0] mac_t;
  typedef logic [7:0]  byte_t;

  ////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////

  // bit 0 run, bit 1 wide spectrum, bit 2 transmit request
  localparam cmd_addr_t ADDR_GENERAL   = 6'h00;
  localparam cmd_addr_t ADDR_STATIC_IP = 6'h3a;
  // alt mac low half in 15:0, eeprom config in 23:16
  localparam cmd_addr_t ADDR_MAC_CFG   = 6'h3b;
  // read only
  localparam cmd_addr_t ADDR_VERSION   = 6'h3f;

  // eeprom config bit selecting the alternate mac
  localparam int CFG_ALT_MAC_BIT = 6;

  ////////////////////////////////////////////////////////////
  // framing
  ////////////////////////////////////////////////////////////

  localparam int CMD_FRAME_BYTES = 5;
  localparam int RESP_BYTES      = 5;

  // top two bits of a response word, bit 7 set and bit 6 clear
  localparam logic [1:0] RESP_MARK = 2'b10;

endpackage

/* hdl/cmd_if.sv */
`timescale 1ns/1ps

// one decoded command, valid in the cycle stb is high
interface cmd_if;

  hl_ctrl_pkg::cmd_addr_t addr;
  hl_ctrl_pkg::cmd_data_t data;
  logic                   resp_rqst;
  logic                   stb;

  // parser side
  modport src (
    output addr,
    output data,
    output resp_rqst,
    output stb
  );

  // register file side
  modport dst (
    input addr,
    input data,
    input resp_rqst,
    input stb
  );

endinterface

/* hdl/cmd_parser.sv */
`timescale 1ns/1ps

module cmd_parser (
  input  logic               clk_ctrl,
  input  logic               rst_i,
  input  logic               udp_rx_active_i,
  input  hl_ctrl_pkg::byte_t udp_rx_data_i,
  cmd_if.src                 cmd
);

  // counts 0 up to a full frame, then saturates
  localparam int CNT_W = $clog2(hl_ctrl_pkg::CMD_FRAME_BYTES + 1);

  localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(hl_ctrl_pkg::CMD_FRAME_BYTES - 1);
  localparam logic [CNT_W-1:0] FULL      = CNT_W'(hl_ctrl_pkg::CMD_FRAME_BYTES);

  logic [CNT_W-1:0] byte_cnt;
  logic             take_byte;

  // bytes past the fifth are dropped
  assign take_byte = udp_rx_active_i && (byte_cnt != FULL);

  ////////////////////////////////////////////////////////////
  // byte counter and strobe
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      byte_cnt <= '0;
      cmd.stb  <= 1'b0;
    end else begin
      // pulse once, right after the last byte of a frame
      cmd.stb <= take_byte && (byte_cnt == LAST_BYTE);

      if (!udp_rx_active_i) begin
        // frame over, short or not
        byte_cnt <= '0;
      end else if (take_byte) begin
        byte_cnt <= byte_cnt + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // field assembly
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (take_byte) begin
      if (byte_cnt == '0) begin
        // header byte
        cmd.addr      <= udp_rx_data_i[5:0];
        cmd.resp_rqst <= udp_rx_data_i[7];
      end else begin
        // data arrives msb first
        cmd.data <= {cmd.data[23:0], udp_rx_data_i};
      end
    end
  end

endmodule

/* hdl/ctrl_regs.sv */
`timescale 1ns/1ps

module ctrl_regs #(
  parameter hl_ctrl_pkg::mac_t BASE_MAC      = 48'h001cc0a213dd,
  parameter logic [7:0]        VERSION_MAJOR = 8'd69,
  parameter logic [7:0]        VERSION_MINOR = 8'd4
) (
  input  logic                   clk_ctrl,
  input  logic                   rst_i,
  cmd_if.dst                     cmd,
  input  logic                   io_tx_inhibit_i,
  input  logic                   io_alternate_mac_i,
  output logic                   run_o,
  output logic                   wide_spectrum_o,
  output logic                   tx_on_o,
  output hl_ctrl_pkg::cmd_data_t static_ip_o,
  output hl_ctrl_pkg::mac_t      local_mac_o,
  output logic                   resp_stb_o,
  output hl_ctrl_pkg::resp_t     resp_o
);

  logic                   tx_req;
  logic [15:0]            alt_mac;
  logic [7:0]             eeprom_config;
  hl_ctrl_pkg::cmd_data_t rdback;

  ////////////////////////////////////////////////////////////
  // register writes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      run_o           <= 1'b0;
      wide_spectrum_o <= 1'b0;
      tx_req          <= 1'b0;
      static_ip_o     <= '0;
      alt_mac         <= '0;
      eeprom_config   <= '0;
    end else if (cmd.stb) begin
      case (cmd.addr)
        hl_ctrl_pkg::ADDR_GENERAL: begin
          run_o           <= cmd.data[0];
          wide_spectrum_o <= cmd.data[1];
          tx_req          <= cmd.data[2];
        end
        hl_ctrl_pkg::ADDR_STATIC_IP: begin
          static_ip_o <= cmd.data;
        end
        hl_ctrl_pkg::ADDR_MAC_CFG: begin
          alt_mac       <= cmd.data[15:0];
          eeprom_config <= cmd.data[23:16];
        end
        // version and unmapped addresses take no write
        default: ;
      endcase
    end
  end

  // value each register holds once the write lands
  always_comb begin
    case (cmd.addr)
      hl_ctrl_pkg::ADDR_GENERAL:   rdback = {29'd0, cmd.data[2:0]};
      hl_ctrl_pkg::ADDR_STATIC_IP: rdback = cmd.data;
      hl_ctrl_pkg::ADDR_MAC_CFG:   rdback = {8'd0, cmd.data[23:0]};
      hl_ctrl_pkg::ADDR_VERSION:   rdback = {16'd0, VERSION_MAJOR, VERSION_MINOR};
      default:                     rdback = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // response capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      resp_stb_o <= 1'b0;
    end else begin
      resp_stb_o <= cmd.stb && cmd.resp_rqst;
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (cmd.stb) begin
      resp_o <= {hl_ctrl_pkg::RESP_MARK, cmd.addr, rdback};
    end
  end

  ////////////////////////////////////////////////////////////
  // derived outputs
  ////////////////////////////////////////////////////////////

  // eeprom choice wins over the strap pin
  assign local_mac_o = eeprom_config[hl_ctrl_pkg::CFG_ALT_MAC_BIT]
                     ? {BASE_MAC[47:16], alt_mac}
                     : {BASE_MAC[47:2], ~io_alternate_mac_i, BASE_MAC[0]};

  // transmit only while running and not inhibited
  assign tx_on_o = tx_req & run_o & ~io_tx_inhibit_i;

endmodule

/* hdl/resp_builder.sv */
`timescale 1ns/1ps

module resp_builder (
  input  logic               clk_ctrl,
  input  logic               rst_i,
  input  logic               resp_stb_i,
  input  hl_ctrl_pkg::resp_t resp_i,
  output logic               udp_tx_request_o,
  input  logic               udp_tx_enable_i,
  output hl_ctrl_pkg::byte_t udp_tx_data_o,
  output logic               udp_tx_valid_o
);

  localparam int CNT_W = $clog2(hl_ctrl_pkg::RESP_BYTES);

  localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(hl_ctrl_pkg::RESP_BYTES - 1);

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    SEND
  } state_t;

  state_t             state;
  hl_ctrl_pkg::resp_t shreg;
  logic [CNT_W-1:0]   byte_cnt;
  logic               send_byte;

  // a byte leaves on every enable cycle once the request is up
  assign send_byte = (state != IDLE) && udp_tx_enable_i;

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      state    <= IDLE;
      byte_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          byte_cnt <= '0;
          if (resp_stb_i) begin
            state <= REQUEST;
          end
        end
        REQUEST: begin
          // first enable is the grant and carries byte 0
          if (udp_tx_enable_i) begin
            state    <= SEND;
            byte_cnt <= byte_cnt + 1'b1;
          end
        end
        SEND: begin
          if (udp_tx_enable_i) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == LAST_BYTE) begin
              state <= IDLE;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // response buffer
  ////////////////////////////////////////////////////////////

  // loads only when idle, so a busy builder drops new strobes
  always_ff @(posedge clk_ctrl) begin
    if (state == IDLE && resp_stb_i) begin
      shreg <= resp_i;
    end else if (send_byte) begin
      shreg <= {shreg[31:0], 8'h00};
    end
  end

  assign udp_tx_request_o = (state == REQUEST);
  assign udp_tx_data_o    = shreg[39:32];
  assign udp_tx_valid_o   = send_byte;

endmodule

/* hdl/hl_ctrl_core.sv */
`timescale 1ns/1ps

module hl_ctrl_core #(
  parameter hl_ctrl_pkg::mac_t BASE_MAC      = 48'h001cc0a213dd,
  parameter logic [7:0]        VERSION_MAJOR = 8'd69,
  parameter logic [7:0]        VERSION_MINOR = 8'd4
) (
  input  logic                   clk_ctrl,
  input  logic                   rst_i,

  // downstream udp payload
  input  logic                   udp_rx_active_i,
  input  hl_ctrl_pkg::byte_t     udp_rx_data_i,

  // upstream udp payload
  output logic                   udp_tx_request_o,
  input  logic                   udp_tx_enable_i,
  output hl_ctrl_pkg::byte_t     udp_tx_data_o,
  output logic                   udp_tx_valid_o,

  // board pins
  input  logic                   io_tx_inhibit_i,
  input  logic                   io_alternate_mac_i,
  output logic                   io_led_run_o,
  output logic                   io_led_tx_o,

  // control state
  output logic                   run_o,
  output logic                   wide_spectrum_o,
  output hl_ctrl_pkg::cmd_data_t static_ip_o,
  output hl_ctrl_pkg::mac_t      local_mac_o,
  output logic                   tx_on_o
);

  logic               resp_stb;
  hl_ctrl_pkg::resp_t resp;

  cmd_if cmd ();

  ////////////////////////////////////////////////////////////
  // command path
  ////////////////////////////////////////////////////////////

  cmd_parser cmd_parser_i (
    .clk_ctrl        (clk_ctrl),
    .rst_i           (rst_i),
    .udp_rx_active_i (udp_rx_active_i),
    .udp_rx_data_i   (udp_rx_data_i),
    .cmd             (cmd.src)
  );

  ctrl_regs #(
    .BASE_MAC      (BASE_MAC),
    .VERSION_MAJOR (VERSION_MAJOR),
    .VERSION_MINOR (VERSION_MINOR)
  ) ctrl_regs_i (
    .clk_ctrl           (clk_ctrl),
    .rst_i              (rst_i),
    .cmd                (cmd.dst),
    .io_tx_inhibit_i    (io_tx_inhibit_i),
    .io_alternate_mac_i (io_alternate_mac_i),
    .run_o              (run_o),
    .wide_spectrum_o    (wide_spectrum_o),
    .tx_on_o            (tx_on_o),
    .static_ip_o        (static_ip_o),
    .local_mac_o        (local_mac_o),
    .resp_stb_o         (resp_stb),
    .resp_o             (resp)
  );

  ////////////////////////////////////////////////////////////
  // response path
  ////////////////////////////////////////////////////////////

  resp_builder resp_builder_i (
    .clk_ctrl         (clk_ctrl),
    .rst_i            (rst_i),
    .resp_stb_i       (resp_stb),
    .resp_i           (resp),
    .udp_tx_request_o (udp_tx_request_o),
    .udp_tx_enable_i  (udp_tx_enable_i),
    .udp_tx_data_o    (udp_tx_data_o),
    .udp_tx_valid_o   (udp_tx_valid_o)
  );

  // front panel leds
  assign io_led_run_o = run_o;
  assign io_led_tx_o  = tx_on_o;

endmodule

/* tests/tb_frames.svh */
// one command frame, a byte per clock, header first
task automatic send_frame(input logic [7:0] hdr, input logic [31:0] data, input int nbytes);
  logic [39:0] frame;
  int          i;
  frame = {hdr, data};
  for (i = 0; i < nbytes; i++) begin
    @(negedge clk_ctrl);
    udp_rx_active_i = 1'b1;
    udp_rx_data_i   = frame[39:32];
    frame = frame << 8;
  end
  @(negedge clk_ctrl);
  udp_rx_active_i = 1'b0;
  udp_rx_data_i   = '0;
endtask

task automatic wait_cycles(input int n);
  repeat (n) @(negedge clk_ctrl);
endtask

////////////////////////////////////////////////////////////
// upstream side
////////////////////////////////////////////////////////////

// random grant and stall pattern until the model has seen every byte
task automatic collect_response(input int max_cycles);
  int n;
  n = 0;
  // model loads the expected word one cycle after the frame ends
  @(negedge clk_ctrl);
  while (tx_left != 0 && n < max_cycles) begin
    // stalls about a third of the time
    udp_tx_enable_i = ($urandom % 3) != 0;
    @(negedge clk_ctrl);
    n++;
  end
  udp_tx_enable_i = 1'b0;
  if (tx_left != 0) begin
    note_failure("response bytes did not all arrive");
  end
endtask

/* tests/hl_ctrl_core_tb.sv */
`timescale 1ns/1ps

module hl_ctrl_core_tb;

  localparam time         CLK_PERIOD      = 100;
  localparam int          NUM_TESTS       = 6;
  localparam int          CYCLES_PER_TEST = 200;
  localparam logic [47:0] BASE_MAC        = 48'h001cc0a213dd;

  logic        clk_ctrl;
  logic        rst_i;
  logic        udp_rx_active_i;
  logic [7:0]  udp_rx_data_i;
  logic        udp_tx_request_o;
  logic        udp_tx_enable_i;
  logic [7:0]  udp_tx_data_o;
  logic        udp_tx_valid_o;
  logic        io_tx_inhibit_i;
  logic        io_alternate_mac_i;
  logic        io_led_run_o;
  logic        io_led_tx_o;
  logic        run_o;
  logic        wide_spectrum_o;
  logic [31:0] static_ip_o;
  logic [47:0] local_mac_o;
  logic        tx_on_o;

  // reference model of the register file and response path
  int          rx_cnt;
  logic [31:0] rx_word;
  logic        pend;
  logic [39:0] pend_word;
  logic        m_run;
  logic        m_wide;
  logic        m_txreq;
  logic [31:0] m_ip;
  logic [15:0] m_alt;
  logic [7:0]  m_cfg;
  logic        resp_due;
  logic        due_d;
  logic [39:0] exp_shift;
  int          tx_left;

  int errors;
  int err_mark;
  int tests_failed;

  task automatic value_err(input string name, input logic [63:0] got, input logic [63:0] want);
    $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
    errors++;
  endtask

  task automatic note_failure(input string what);
    $display("%s at %0t", what, $time);
    errors++;
  endtask

  task automatic expect_low(input string name, input logic value);
    assert (value == 1'b0)
      else value_err(name, 64'(value), 64'd0);
  endtask

  task automatic end_test(input string name);
    if (errors == err_mark) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d error(s)", name, errors - err_mark);
      tests_failed++;
    end
    err_mark = errors;
  endtask

  // eeprom config bit 6 picks the written low half and otherwise the strap flips bit 1
  function automatic logic [47:0] mac_expect(input logic [7:0] cfg, input logic [15:0] alt,
                                             input logic pin);
    if (cfg[hl_ctrl_pkg::CFG_ALT_MAC_BIT]) begin
      return {BASE_MAC[47:16], alt};
    end
    return {BASE_MAC[47:2], ~pin, BASE_MAC[0]};
  endfunction

  `include "tb_frames.svh"

  hl_ctrl_core dut (.*);

  initial begin
    clk_ctrl = 1'b0;
    forever #(CLK_PERIOD / 2) clk_ctrl = ~clk_ctrl;
  end

  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("timeout, the test sequence did not finish in %0d cycles",
             NUM_TESTS * CYCLES_PER_TEST);
    $display("ERRORS FOUND");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  always @(posedge clk_ctrl) begin : ref_model
    logic [31:0] rd;
    rd = '0;
    due_d    <= resp_due;
    resp_due <= 1'b0;
    pend     <= 1'b0;
    if (rst_i) begin
      rx_cnt  <= 0;
      m_run   <= 1'b0;
      m_wide  <= 1'b0;
      m_txreq <= 1'b0;
      m_ip    <= '0;
      m_alt   <= '0;
      m_cfg   <= '0;
      tx_left <= 0;
    end else begin
      if (!udp_rx_active_i) begin
        rx_cnt <= 0;
      end else if (rx_cnt < hl_ctrl_pkg::CMD_FRAME_BYTES) begin
        rx_cnt  <= rx_cnt + 1;
        rx_word <= {rx_word[23:0], udp_rx_data_i};
        if (rx_cnt == hl_ctrl_pkg::CMD_FRAME_BYTES - 1) begin
          pend      <= 1'b1;
          pend_word <= {rx_word, udp_rx_data_i};
        end
      end
      if (udp_tx_valid_o) begin
        exp_shift <= exp_shift << 8;
        tx_left   <= tx_left - 1;
      end
      // parser stage, then the write lands
      if (pend) begin
        case (pend_word[37:32])
          hl_ctrl_pkg::ADDR_GENERAL: begin
            m_run   <= pend_word[0];
            m_wide  <= pend_word[1];
            m_txreq <= pend_word[2];
            rd = {29'd0, pend_word[2:0]};
          end
          hl_ctrl_pkg::ADDR_STATIC_IP: begin
            m_ip <= pend_word[31:0];
            rd = pend_word[31:0];
          end
          hl_ctrl_pkg::ADDR_MAC_CFG: begin
            m_alt <= pend_word[15:0];
            m_cfg <= pend_word[23:16];
            rd = {8'd0, pend_word[23:0]};
          end
          hl_ctrl_pkg::ADDR_VERSION: rd = {16'd0, 8'd69, 8'd4};
          default: rd = '0;
        endcase
        if (pend_word[39]) begin
          resp_due  <= 1'b1;
          exp_shift <= {8'h80 | {2'b00, pend_word[37:32]}, rd};
          tx_left   <= hl_ctrl_pkg::RESP_BYTES;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  a_run: assert property (@(posedge clk_ctrl) disable iff (rst_i) run_o == m_run)
    else value_err("run_o", 64'($sampled(run_o)), 64'($sampled(m_run)));
  a_led_run: assert property (@(posedge clk_ctrl) disable iff (rst_i) io_led_run_o == m_run)
    else value_err("io_led_run_o", 64'($sampled(io_led_run_o)), 64'($sampled(m_run)));
  a_wide: assert property (@(posedge clk_ctrl) disable iff (rst_i) wide_spectrum_o == m_wide)
    else value_err("wide_spectrum_o", 64'($sampled(wide_spectrum_o)), 64'($sampled(m_wide)));
  a_ip: assert property (@(posedge clk_ctrl) disable iff (rst_i) static_ip_o == m_ip)
    else value_err("static_ip_o", 64'($sampled(static_ip_o)), 64'($sampled(m_ip)));
  a_mac: assert property (@(posedge clk_ctrl) disable iff (rst_i)
                          local_mac_o == mac_expect(m_cfg, m_alt, io_alternate_mac_i))
    else value_err("local_mac_o", 64'($sampled(local_mac_o)),
                   64'(mac_expect($sampled(m_cfg), $sampled(m_alt),
                                  $sampled(io_alternate_mac_i))));
  a_tx_on: assert property (@(posedge clk_ctrl) disable iff (rst_i)
                            tx_on_o == (m_txreq & m_run & ~io_tx_inhibit_i))
    else value_err("tx_on_o", 64'($sampled(tx_on_o)), 64'($sampled(m_txreq & m_run &
                   ~io_tx_inhibit_i)));
  a_led_tx: assert property (@(posedge clk_ctrl) disable iff (rst_i)
                             io_led_tx_o == (m_txreq & m_run & ~io_tx_inhibit_i))
    else value_err("io_led_tx_o", 64'($sampled(io_led_tx_o)), 64'($sampled(m_txreq & m_run &
                   ~io_tx_inhibit_i)));
  a_req_cause: assert property (@(posedge clk_ctrl) disable iff (rst_i)
                                $rose(udp_tx_request_o) |-> due_d)
    else note_failure("udp_tx_request_o rose without a response request");
  a_req_time: assert property (@(posedge clk_ctrl) disable iff (rst_i)
                               due_d |-> $rose(udp_tx_request_o))
    else note_failure("udp_tx_request_o did not rise 3 cycles after the fifth byte");
  a_tx_byte: assert property (@(posedge clk_ctrl) disable iff (rst_i)
                              udp_tx_valid_o |-> udp_tx_data_o == exp_shift[39:32])
    else value_err("udp_tx_data_o", 64'($sampled(udp_tx_data_o)),
                   64'($sampled(exp_shift[39:32])));
  a_tx_count: assert property (@(posedge clk_ctrl) disable iff (rst_i)
                               udp_tx_valid_o |-> tx_left > 0)
    else note_failure("udp_tx_valid_o high after the last response byte");
  // a stalled cycle sends nothing
  a_tx_stall: assert property (@(posedge clk_ctrl) disable iff (rst_i)
                               udp_tx_valid_o |-> udp_tx_enable_i)
    else note_failure("udp_tx_valid_o high in a cycle with udp_tx_enable_i low");

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'he226));
    errors             = 0;
    err_mark           = 0;
    tests_failed       = 0;
    rst_i              = 1'b1;
    udp_rx_active_i    = 1'b0;
    udp_rx_data_i      = '0;
    udp_tx_enable_i    = 1'b0;
    io_tx_inhibit_i    = 1'b0;
    io_alternate_mac_i = 1'b0;
    repeat (3) @(negedge clk_ctrl);
    rst_i = 1'b0;

    @(negedge clk_ctrl);
    expect_low("udp_tx_request_o", udp_tx_request_o);
    expect_low("udp_tx_valid_o", udp_tx_valid_o);
    expect_low("tx_on_o", tx_on_o);
    expect_low("io_led_run_o", io_led_run_o);
    expect_low("io_led_tx_o", io_led_tx_o);
    end_test("reset state");

    send_frame({2'b00, hl_ctrl_pkg::ADDR_GENERAL}, $urandom | 32'h3, 5);
    wait_cycles(6);
    end_test("general register write");

    repeat (2) begin
      send_frame({2'b10, hl_ctrl_pkg::ADDR_STATIC_IP}, $urandom, 5);
      collect_response(60);
    end
    end_test("static ip response");

    send_frame({2'b10, hl_ctrl_pkg::ADDR_VERSION}, $urandom, 5);
    collect_response(60);
    send_frame({2'b10, 6'h15}, $urandom, 5);
    collect_response(60);
    send_frame({2'b10, hl_ctrl_pkg::ADDR_STATIC_IP}, $urandom, 4);
    wait_cycles(6);
    end_test("version, unknown address, short frame");

    // strap pin first, then the eeprom choice
    io_alternate_mac_i = 1'b1;
    wait_cycles(3);
    io_alternate_mac_i = 1'b0;
    wait_cycles(3);
    send_frame({2'b00, hl_ctrl_pkg::ADDR_MAC_CFG}, ($urandom & 32'h00ff_ffff) | 32'h0040_0000, 5);
    wait_cycles(3);
    io_alternate_mac_i = 1'b1;
    wait_cycles(3);
    end_test("mac selection");

    for (int k = 0; k < 8; k++) begin
      io_tx_inhibit_i = k[2];
      send_frame({2'b00, hl_ctrl_pkg::ADDR_GENERAL}, {29'd0, k[0], 1'b0, k[1]}, 5);
      wait_cycles(3);
      io_tx_inhibit_i = ~io_tx_inhibit_i;
      wait_cycles(2);
    end
    end_test("transmit gating");

    $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* hl_ctrl_core.f */
+incdir+tests
hdl/hl_ctrl_pkg.sv
hdl/cmd_if.sv
hdl/cmd_parser.sv
hdl/ctrl_regs.sv
hdl/resp_builder.sv
hdl/hl_ctrl_core.sv
tests/hl_ctrl_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP       := hl_ctrl_core_tb
RTL_TOP   := hl_ctrl_core
FILELIST  := hl_ctrl_core.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := NO ERRORS
SOURCES   := $(wildcard hdl/*.sv tests/*.sv tests/*.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
